/* hw/csr_pkg.sv */
`default_nettype none

package csr_pkg;

  // default register width of the core
  localparam int XLEN_DEFAULT = 64;

  typedef logic [11:0] csr_addr_t;

  // machine-mode CSR addresses
  localparam csr_addr_t CSR_MSTATUS = 12'h300;
  localparam csr_addr_t CSR_MIE     = 12'h304;
  localparam csr_addr_t CSR_MTVEC   = 12'h305;
  localparam csr_addr_t CSR_MEPC    = 12'h341;
  localparam csr_addr_t CSR_MCAUSE  = 12'h342;
  localparam csr_addr_t CSR_MTVAL   = 12'h343;
  localparam csr_addr_t CSR_MIP     = 12'h344;

  // low bits of funct3 with 2'b00 left unused
  typedef enum logic [1:0] {
    CSR_RW = 2'b01,
    CSR_RS = 2'b10,
    CSR_RC = 2'b11
  } csr_op_e;

  // mstatus fields
  localparam int MSTATUS_MIE_BIT  = 3;
  localparam int MSTATUS_MPIE_BIT = 7;
  localparam int MSTATUS_MPP_LO   = 11;
  localparam int MSTATUS_MPP_HI   = 12;

  // timer interrupt bits in mip and mie
  localparam int MIP_MTIP_BIT = 7;
  localparam int MIE_MTIE_BIT = 7;

  // exception code of the machine timer interrupt
  localparam int CAUSE_TIMER_INT_CODE = 7;

  // MPP = machine mode, all else clear
  localparam logic [XLEN_DEFAULT-1:0] MSTATUS_RESET = 64'h0000_0000_0000_1800;

endpackage

`default_nettype wire

/* hw/trap_write_if.sv */
`timescale 1ns/100ps
`default_nettype none

// dedicated CSR writes from the trap logic
interface trap_write_if #(
  parameter int XLEN = csr_pkg::XLEN_DEFAULT
);

  logic [XLEN-1:0] mstatus_data;
  logic [XLEN-1:0] mepc_data;
  logic [XLEN-1:0] mcause_data;
  logic [XLEN-1:0] mtval_data;

  logic mstatus_we;
  logic mepc_we;
  logic mcause_we;
  logic mtval_we;

  modport trap (
    output mstatus_data,
    output mepc_data,
    output mcause_data,
    output mtval_data,
    output mstatus_we,
    output mepc_we,
    output mcause_we,
    output mtval_we
  );

  modport regfile (
    input mstatus_data,
    input mepc_data,
    input mcause_data,
    input mtval_data,
    input mstatus_we,
    input mepc_we,
    input mcause_we,
    input mtval_we
  );

endinterface

`default_nettype wire

/* hw/csr_op_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module csr_op_unit #(
  parameter int XLEN = csr_pkg::XLEN_DEFAULT
) (
  input  logic               csr_valid_i,
  input  csr_pkg::csr_op_e   csr_op_i,
  input  logic [XLEN-1:0]    csr_operand_i,
  input  logic [XLEN-1:0]    old_value_i,
  output logic [XLEN-1:0]    new_value_o,
  output logic               wr_en_o
);

  logic set_or_clear;
  logic operand_zero;

  always_comb begin
    case (csr_op_i)
      csr_pkg::CSR_RW: begin
        new_value_o = csr_operand_i;
      end
      csr_pkg::CSR_RS: begin
        new_value_o = old_value_i | csr_operand_i;
      end
      csr_pkg::CSR_RC: begin
        new_value_o = old_value_i & ~csr_operand_i;
      end
      default: begin
        new_value_o = old_value_i;
      end
    endcase
  end

  assign set_or_clear = (csr_op_i == csr_pkg::CSR_RS) || (csr_op_i == csr_pkg::CSR_RC);
  assign operand_zero = (csr_operand_i == '0);

  // set/clear with rs1 = x0 only reads
  assign wr_en_o = csr_valid_i && !(set_or_clear && operand_zero);

  // the decoder upstream never issues the spare encoding
  always_comb begin
    if (csr_valid_i) begin
      assert final (csr_op_i inside {csr_pkg::CSR_RW, csr_pkg::CSR_RS, csr_pkg::CSR_RC})
        else $error("csr_op_unit: unused op encoding with csr_valid_i high");
    end
  end

endmodule

`default_nettype wire

/* hw/trap_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module trap_unit #(
  parameter int XLEN = csr_pkg::XLEN_DEFAULT
) (
  input  logic            exception_i,
  input  logic [XLEN-1:0] exception_cause_i,
  input  logic [XLEN-1:0] exception_tval_i,
  input  logic [XLEN-1:0] pc_i,
  input  logic            mret_i,
  input  logic [XLEN-1:0] mstatus_i,
  input  logic [XLEN-1:0] mtvec_i,
  input  logic [XLEN-1:0] mepc_i,
  input  logic [XLEN-1:0] mie_i,
  input  logic [XLEN-1:0] mip_i,
  trap_write_if.trap      tw,
  output logic            trap_taken_o,
  output logic            mret_taken_o,
  output logic [XLEN-1:0] redirect_pc_o
);

  logic            irq_pending;
  logic            take_irq;
  logic [XLEN-1:0] irq_cause;
  logic [XLEN-1:0] entry_status;
  logic [XLEN-1:0] return_status;

  assign irq_pending = mip_i[csr_pkg::MIP_MTIP_BIT]
                     & mie_i[csr_pkg::MIE_MTIE_BIT]
                     & mstatus_i[csr_pkg::MSTATUS_MIE_BIT];

  // exception > interrupt > mret
  assign take_irq     = irq_pending && !exception_i;
  assign trap_taken_o = exception_i || take_irq;
  assign mret_taken_o = mret_i && !trap_taken_o;

  // interrupt flag in the top bit
  assign irq_cause = {1'b1, (XLEN-1)'(csr_pkg::CAUSE_TIMER_INT_CODE)};

  // stack MIE into MPIE on entry
  always_comb begin
    entry_status = mstatus_i;
    entry_status[csr_pkg::MSTATUS_MPIE_BIT] = mstatus_i[csr_pkg::MSTATUS_MIE_BIT];
    entry_status[csr_pkg::MSTATUS_MIE_BIT]  = 1'b0;
  end

  // and pop it back on mret
  always_comb begin
    return_status = mstatus_i;
    return_status[csr_pkg::MSTATUS_MIE_BIT]  = mstatus_i[csr_pkg::MSTATUS_MPIE_BIT];
    return_status[csr_pkg::MSTATUS_MPIE_BIT] = 1'b1;
  end

  assign tw.mstatus_data = trap_taken_o ? entry_status : return_status;
  assign tw.mepc_data    = pc_i;
  assign tw.mcause_data  = exception_i ? exception_cause_i : irq_cause;
  assign tw.mtval_data   = exception_i ? exception_tval_i : '0;

  assign tw.mstatus_we = trap_taken_o || mret_taken_o;
  assign tw.mepc_we    = trap_taken_o;
  assign tw.mcause_we  = trap_taken_o;
  assign tw.mtval_we   = trap_taken_o;

  // direct mode only, so the base is the vector
  always_comb begin
    if (trap_taken_o) begin
      redirect_pc_o = {mtvec_i[XLEN-1:2], 2'b00};
    end else if (mret_taken_o) begin
      redirect_pc_o = mepc_i;
    end else begin
      redirect_pc_o = '0;
    end
  end

endmodule

`default_nettype wire

/* hw/csr_regfile.sv */
`timescale 1ns/100ps
`default_nettype none

module csr_regfile #(
  parameter int XLEN = csr_pkg::XLEN_DEFAULT
) (
  input  logic               clk,
  input  logic               reset_i,
  input  csr_pkg::csr_addr_t rd_addr_i,
  output logic [XLEN-1:0]    rd_data_o,
  input  csr_pkg::csr_addr_t wr_addr_i,
  input  logic               wr_en_i,
  input  logic [XLEN-1:0]    wr_data_i,
  trap_write_if.regfile      tw,
  input  logic               timer_irq_i,
  output logic [XLEN-1:0]    mstatus_o,
  output logic [XLEN-1:0]    mtvec_o,
  output logic [XLEN-1:0]    mepc_o,
  output logic [XLEN-1:0]    mie_o,
  output logic [XLEN-1:0]    mip_o
);

  logic [XLEN-1:0] mstatus_q;
  logic [XLEN-1:0] mepc_q;
  logic [XLEN-1:0] mcause_q;
  logic [XLEN-1:0] mtval_q;
  logic [XLEN-1:0] mtvec_q;
  logic [XLEN-1:0] mie_q;
  logic            mtip_q;
  logic [XLEN-1:0] mip_value;

  logic sel_mstatus;
  logic sel_mepc;
  logic sel_mcause;
  logic sel_mtval;
  logic sel_mtvec;
  logic sel_mie;

  // only machine mode exists
  function automatic logic [XLEN-1:0] with_mpp(input logic [XLEN-1:0] value);
    logic [XLEN-1:0] result;
    result = value;
    result[csr_pkg::MSTATUS_MPP_HI:csr_pkg::MSTATUS_MPP_LO] = 2'b11;
    return result;
  endfunction

  // instruction write decode with no entry for mip
  assign sel_mstatus = wr_en_i && (wr_addr_i == csr_pkg::CSR_MSTATUS);
  assign sel_mepc    = wr_en_i && (wr_addr_i == csr_pkg::CSR_MEPC);
  assign sel_mcause  = wr_en_i && (wr_addr_i == csr_pkg::CSR_MCAUSE);
  assign sel_mtval   = wr_en_i && (wr_addr_i == csr_pkg::CSR_MTVAL);
  assign sel_mtvec   = wr_en_i && (wr_addr_i == csr_pkg::CSR_MTVEC);
  assign sel_mie     = wr_en_i && (wr_addr_i == csr_pkg::CSR_MIE);

  // trap writes win per register
  always_ff @(posedge clk) begin
    if (reset_i) begin
      mstatus_q <= csr_pkg::MSTATUS_RESET[XLEN-1:0];
      mepc_q    <= '0;
      mcause_q  <= '0;
      mtval_q   <= '0;
      mtvec_q   <= '0;
      mie_q     <= '0;
      mtip_q    <= 1'b0;
    end else begin
      if (tw.mstatus_we) begin
        mstatus_q <= with_mpp(tw.mstatus_data);
      end else if (sel_mstatus) begin
        mstatus_q <= with_mpp(wr_data_i);
      end
      if (tw.mepc_we) begin
        mepc_q <= tw.mepc_data;
      end else if (sel_mepc) begin
        mepc_q <= wr_data_i;
      end
      if (tw.mcause_we) begin
        mcause_q <= tw.mcause_data;
      end else if (sel_mcause) begin
        mcause_q <= wr_data_i;
      end
      if (tw.mtval_we) begin
        mtval_q <= tw.mtval_data;
      end else if (sel_mtval) begin
        mtval_q <= wr_data_i;
      end
      if (sel_mtvec) begin
        mtvec_q <= wr_data_i;
      end
      if (sel_mie) begin
        mie_q <= wr_data_i;
      end
      // timer line sampled every cycle
      mtip_q <= timer_irq_i;
    end
  end

  always_comb begin
    mip_value = '0;
    mip_value[csr_pkg::MIP_MTIP_BIT] = mtip_q;
  end

  always_comb begin
    case (rd_addr_i)
      csr_pkg::CSR_MSTATUS: rd_data_o = mstatus_q;
      csr_pkg::CSR_MEPC:    rd_data_o = mepc_q;
      csr_pkg::CSR_MCAUSE:  rd_data_o = mcause_q;
      csr_pkg::CSR_MTVAL:   rd_data_o = mtval_q;
      csr_pkg::CSR_MTVEC:   rd_data_o = mtvec_q;
      csr_pkg::CSR_MIE:     rd_data_o = mie_q;
      csr_pkg::CSR_MIP:     rd_data_o = mip_value;
      default:              rd_data_o = '0;
    endcase
  end

  assign mstatus_o = mstatus_q;
  assign mtvec_o   = mtvec_q;
  assign mepc_o    = mepc_q;
  assign mie_o     = mie_q;
  assign mip_o     = mip_value;

  mpp_machine_mode: assert property (@(posedge clk) disable iff (reset_i)
    mstatus_q[csr_pkg::MSTATUS_MPP_HI:csr_pkg::MSTATUS_MPP_LO] == 2'b11)
    else $error("csr_regfile: mstatus.MPP left machine mode");

  // trap entry updates mepc, mcause, mtval and mstatus together
  trap_entry_group: assert property (@(posedge clk) disable iff (reset_i)
    tw.mepc_we |-> (tw.mstatus_we && tw.mcause_we && tw.mtval_we))
    else $error("csr_regfile: partial trap entry write");

endmodule

`default_nettype wire

/* hw/csr_top.sv */
`timescale 1ns/100ps
`default_nettype none

module csr_top #(
  parameter int XLEN = csr_pkg::XLEN_DEFAULT
) (
  input  logic            clk,
  input  logic            reset_i,
  input  logic            csr_valid_i,
  input  logic [1:0]      csr_op_i,
  input  logic [11:0]     csr_addr_i,
  input  logic [XLEN-1:0] csr_operand_i,
  output logic [XLEN-1:0] csr_rdata_o,
  input  logic            exception_i,
  input  logic [XLEN-1:0] exception_cause_i,
  input  logic [XLEN-1:0] exception_tval_i,
  input  logic [XLEN-1:0] pc_i,
  input  logic            mret_i,
  input  logic            timer_irq_i,
  output logic            trap_taken_o,
  output logic            mret_taken_o,
  output logic [XLEN-1:0] redirect_pc_o
);

  csr_pkg::csr_op_e csr_op;
  logic [XLEN-1:0]  new_value;
  logic             wr_en;
  logic [XLEN-1:0]  mstatus;
  logic [XLEN-1:0]  mtvec;
  logic [XLEN-1:0]  mepc;
  logic [XLEN-1:0]  mie;
  logic [XLEN-1:0]  mip;

  assign csr_op = csr_pkg::csr_op_e'(csr_op_i);

  trap_write_if #(.XLEN(XLEN)) u_trap_write ();

  csr_op_unit #(.XLEN(XLEN)) u_op_unit (
    .csr_valid_i  (csr_valid_i),
    .csr_op_i     (csr_op),
    .csr_operand_i(csr_operand_i),
    .old_value_i  (csr_rdata_o),
    .new_value_o  (new_value),
    .wr_en_o      (wr_en)
  );

  trap_unit #(.XLEN(XLEN)) u_trap_unit (
    .exception_i      (exception_i),
    .exception_cause_i(exception_cause_i),
    .exception_tval_i (exception_tval_i),
    .pc_i             (pc_i),
    .mret_i           (mret_i),
    .mstatus_i        (mstatus),
    .mtvec_i          (mtvec),
    .mepc_i           (mepc),
    .mie_i            (mie),
    .mip_i            (mip),
    .tw               (u_trap_write.trap),
    .trap_taken_o     (trap_taken_o),
    .mret_taken_o     (mret_taken_o),
    .redirect_pc_o    (redirect_pc_o)
  );

  csr_regfile #(.XLEN(XLEN)) u_regfile (
    .clk        (clk),
    .reset_i    (reset_i),
    .rd_addr_i  (csr_addr_i),
    .rd_data_o  (csr_rdata_o),
    .wr_addr_i  (csr_addr_i),
    .wr_en_i    (wr_en),
    .wr_data_i  (new_value),
    .tw         (u_trap_write.regfile),
    .timer_irq_i(timer_irq_i),
    .mstatus_o  (mstatus),
    .mtvec_o    (mtvec),
    .mepc_o     (mepc),
    .mie_o      (mie),
    .mip_o      (mip)
  );

endmodule

`default_nettype wire

/* tb/csr_checker.sv */
`timescale 1ns/100ps
`default_nettype none

// compares DUT outputs with the model values at every rising edge
module csr_checker #(
  parameter int XLEN = 64
) (
  input  logic            clk,
  input  logic            reset_i,
  input  logic [XLEN-1:0] rdata_i,
  input  logic            trap_taken_i,
  input  logic            mret_taken_i,
  input  logic [XLEN-1:0] redirect_pc_i,
  input  logic [XLEN-1:0] exp_rdata_i,
  input  logic            exp_trap_i,
  input  logic            exp_mret_i,
  input  logic [XLEN-1:0] exp_redirect_i,
  input  logic            test_done_i,
  input  int              test_id_i,
  output int              checks_o,
  output int              errors_o
);

  int test_checks = 0;
  int test_errors = 0;
  int total_checks = 0;
  int total_errors = 0;

  function automatic string test_name(input int id);
    case (id)
      0: return "reset";
      1: return "csr_ops";
      2: return "exception";
      3: return "timer_irq";
      4: return "mret";
      5: return "conflict";
      default: return "unknown";
    endcase
  endfunction

  task automatic compare(input string name, input logic [XLEN-1:0] got,
                         input logic [XLEN-1:0] exp);
    test_checks++;
    if (got !== exp) begin
      test_errors++;
      $display("CHECK FAILED %s: got 0x%h, expected 0x%h at %0t ns", name, got, exp, $time);
    end
  endtask

  // inputs settle at the falling edge, so they are stable here
  always @(posedge clk) begin
    if (!reset_i) begin
      compare("csr_rdata_o", rdata_i, exp_rdata_i);
      compare("trap_taken_o", XLEN'(trap_taken_i), XLEN'(exp_trap_i));
      compare("mret_taken_o", XLEN'(mret_taken_i), XLEN'(exp_mret_i));
      compare("redirect_pc_o", redirect_pc_i, exp_redirect_i);
    end
    if (test_done_i) begin
      $display("test %-10s %0d checks, %0d errors", test_name(test_id_i),
               test_checks, test_errors);
      total_checks += test_checks;
      total_errors += test_errors;
      test_checks = 0;
      test_errors = 0;
    end
  end

  assign checks_o = total_checks;
  assign errors_o = total_errors;

endmodule

`default_nettype wire

/* tb/csr_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module csr_tb;

  localparam int XLEN = 64;
  localparam logic [31:0] SEED = 32'd58;
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
  localparam int RESET_CYCLES = 8;
  localparam int PHASE_LIMIT = 3000;

  // test ids as the checker names them
  localparam int T_RESET = 0;
  localparam int T_CSR = 1;
  localparam int T_EXC = 2;
  localparam int T_IRQ = 3;
  localparam int T_MRET = 4;
  localparam int T_CONFLICT = 5;

  localparam logic [XLEN-1:0] MPP_MACHINE = XLEN'(3) << csr_pkg::MSTATUS_MPP_LO;
  localparam logic [XLEN-1:0] IRQ_CAUSE =
    (XLEN'(1) << (XLEN - 1)) | XLEN'(csr_pkg::CAUSE_TIMER_INT_CODE);

  logic            clk = 1'b0;
  logic            reset_i;
  logic            csr_valid_i;
  logic [1:0]      csr_op_i;
  logic [11:0]     csr_addr_i;
  logic [XLEN-1:0] csr_operand_i;
  logic [XLEN-1:0] csr_rdata_o;
  logic            exception_i;
  logic [XLEN-1:0] exception_cause_i;
  logic [XLEN-1:0] exception_tval_i;
  logic [XLEN-1:0] pc_i;
  logic            mret_i;
  logic            timer_irq_i;
  logic            trap_taken_o;
  logic            mret_taken_o;
  logic [XLEN-1:0] redirect_pc_o;

  // reference state of the seven CSRs
  logic [XLEN-1:0] m_mstatus;
  logic [XLEN-1:0] m_mepc;
  logic [XLEN-1:0] m_mcause;
  logic [XLEN-1:0] m_mtval;
  logic [XLEN-1:0] m_mtvec;
  logic [XLEN-1:0] m_mie;
  logic            m_mtip;
  logic [XLEN-1:0] m_new;
  logic            m_wr;
  logic            m_irq;
  logic [XLEN-1:0] exp_rdata;
  logic            exp_trap;
  logic            exp_mret;
  logic [XLEN-1:0] exp_redirect;

  int n_writes = 0;
  int n_exc = 0;
  int n_irq = 0;
  int n_mret = 0;
  int n_conflict = 0;

  logic [31:0] lfsr;
  logic        test_done;
  int          test_id;
  int          tests_run;
  int          timeouts;
  int          total_checks;
  int          total_errors;

  always #20 clk = ~clk;

  csr_top #(.XLEN(XLEN)) dut (
    .clk              (clk),
    .reset_i          (reset_i),
    .csr_valid_i      (csr_valid_i),
    .csr_op_i         (csr_op_i),
    .csr_addr_i       (csr_addr_i),
    .csr_operand_i    (csr_operand_i),
    .csr_rdata_o      (csr_rdata_o),
    .exception_i      (exception_i),
    .exception_cause_i(exception_cause_i),
    .exception_tval_i (exception_tval_i),
    .pc_i             (pc_i),
    .mret_i           (mret_i),
    .timer_irq_i      (timer_irq_i),
    .trap_taken_o     (trap_taken_o),
    .mret_taken_o     (mret_taken_o),
    .redirect_pc_o    (redirect_pc_o)
  );

  csr_checker #(.XLEN(XLEN)) u_checker (
    .clk           (clk),
    .reset_i       (reset_i),
    .rdata_i       (csr_rdata_o),
    .trap_taken_i  (trap_taken_o),
    .mret_taken_i  (mret_taken_o),
    .redirect_pc_i (redirect_pc_o),
    .exp_rdata_i   (exp_rdata),
    .exp_trap_i    (exp_trap),
    .exp_mret_i    (exp_mret),
    .exp_redirect_i(exp_redirect),
    .test_done_i   (test_done),
    .test_id_i     (test_id),
    .checks_o      (total_checks),
    .errors_o      (total_errors)
  );

  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ LFSR_TAPS) : (state >> 1);
  endfunction

  // one LFSR step per bit
  function automatic logic [63:0] take_bits(input int n);
    logic [63:0] value;
    value = '0;
    for (int i = 0; i < n; i++) begin
      value = {value[62:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
    return value;
  endfunction

  // true once in 2**n
  function automatic logic chance(input int n);
    return (take_bits(n) == '0);
  endfunction

  function automatic csr_pkg::csr_addr_t csr_at(input int idx);
    case (idx)
      0: return csr_pkg::CSR_MSTATUS;
      1: return csr_pkg::CSR_MEPC;
      2: return csr_pkg::CSR_MCAUSE;
      3: return csr_pkg::CSR_MTVAL;
      4: return csr_pkg::CSR_MTVEC;
      5: return csr_pkg::CSR_MIE;
      6: return csr_pkg::CSR_MIP;
      default: return 12'h7c0;
    endcase
  endfunction

  function automatic csr_pkg::csr_addr_t pick_addr(input logic trap_regs);
    logic [3:0] sel;
    sel = 4'(take_bits(4));
    if (trap_regs) begin
      return csr_at(int'(sel[1:0]));
    end else if (sel >= 4'd14) begin
      return 12'(take_bits(12));
    end
    return csr_at(int'(sel) % 7);
  endfunction

  // mstatus after trap entry or after mret
  function automatic logic [XLEN-1:0] trap_status(input logic [XLEN-1:0] st,
                                                  input logic entering);
    logic [XLEN-1:0] next;
    next = st;
    if (entering) begin
      next[csr_pkg::MSTATUS_MPIE_BIT] = st[csr_pkg::MSTATUS_MIE_BIT];
      next[csr_pkg::MSTATUS_MIE_BIT] = 1'b0;
    end else begin
      next[csr_pkg::MSTATUS_MIE_BIT] = st[csr_pkg::MSTATUS_MPIE_BIT];
      next[csr_pkg::MSTATUS_MPIE_BIT] = 1'b1;
    end
    return next | MPP_MACHINE;
  endfunction

  always_comb begin
    case (csr_addr_i)
      csr_pkg::CSR_MSTATUS: exp_rdata = m_mstatus;
      csr_pkg::CSR_MEPC:    exp_rdata = m_mepc;
      csr_pkg::CSR_MCAUSE:  exp_rdata = m_mcause;
      csr_pkg::CSR_MTVAL:   exp_rdata = m_mtval;
      csr_pkg::CSR_MTVEC:   exp_rdata = m_mtvec;
      csr_pkg::CSR_MIE:     exp_rdata = m_mie;
      csr_pkg::CSR_MIP:     exp_rdata = XLEN'(m_mtip) << csr_pkg::MIP_MTIP_BIT;
      default:              exp_rdata = '0;
    endcase
    case (csr_op_i)
      csr_pkg::CSR_RW: m_new = csr_operand_i;
      csr_pkg::CSR_RS: m_new = exp_rdata | csr_operand_i;
      default:         m_new = exp_rdata & ~csr_operand_i;
    endcase
    m_wr = csr_valid_i && (csr_op_i == csr_pkg::CSR_RW || csr_operand_i != '0);
    m_irq = m_mtip && m_mie[csr_pkg::MIE_MTIE_BIT] && m_mstatus[csr_pkg::MSTATUS_MIE_BIT]
            && !exception_i;
    exp_trap = exception_i || m_irq;
    exp_mret = mret_i && !exp_trap;
    if (exp_trap) begin
      exp_redirect = m_mtvec & ~XLEN'(3);
    end else if (exp_mret) begin
      exp_redirect = m_mepc;
    end else begin
      exp_redirect = '0;
    end
  end

  always @(posedge clk) begin
    if (reset_i) begin
      m_mstatus <= MPP_MACHINE;
      m_mepc <= '0;
      m_mcause <= '0;
      m_mtval <= '0;
      m_mtvec <= '0;
      m_mie <= '0;
      m_mtip <= 1'b0;
    end else begin
      if (exp_trap) begin
        m_mstatus <= trap_status(m_mstatus, 1'b1);
        m_mepc <= pc_i;
        m_mcause <= exception_i ? exception_cause_i : IRQ_CAUSE;
        m_mtval <= exception_i ? exception_tval_i : '0;
      end else if (exp_mret) begin
        m_mstatus <= trap_status(m_mstatus, 1'b0);
      end
      // instruction write only where no trap write competes
      if (m_wr) begin
        case (csr_addr_i)
          csr_pkg::CSR_MSTATUS: if (!exp_trap && !exp_mret) m_mstatus <= m_new | MPP_MACHINE;
          csr_pkg::CSR_MEPC:    if (!exp_trap) m_mepc <= m_new;
          csr_pkg::CSR_MCAUSE:  if (!exp_trap) m_mcause <= m_new;
          csr_pkg::CSR_MTVAL:   if (!exp_trap) m_mtval <= m_new;
          csr_pkg::CSR_MTVEC:   m_mtvec <= m_new;
          csr_pkg::CSR_MIE:     m_mie <= m_new;
          default: ;
        endcase
      end
      m_mtip <= timer_irq_i;
      n_writes <= n_writes + int'(m_wr);
      n_exc <= n_exc + int'(exception_i);
      n_irq <= n_irq + int'(m_irq);
      n_mret <= n_mret + int'(exp_mret);
      n_conflict <= n_conflict + int'(exp_trap && m_wr && (csr_addr_i inside
        {csr_pkg::CSR_MSTATUS, csr_pkg::CSR_MEPC, csr_pkg::CSR_MCAUSE, csr_pkg::CSR_MTVAL}));
    end
  end

  function automatic int events_of(input int id);
    case (id)
      T_CSR:      return n_writes;
      T_EXC:      return n_exc;
      T_IRQ:      return n_irq;
      T_MRET:     return n_mret;
      T_CONFLICT: return n_conflict;
      default:    return 0;
    endcase
  endfunction

  task automatic idle_inputs();
    csr_valid_i = 1'b0;
    exception_i = 1'b0;
    mret_i = 1'b0;
  endtask

  task automatic drive_inputs(input int mode);
    csr_valid_i = (mode == T_CONFLICT) || !chance(2);
    csr_op_i = 2'(take_bits(2));
    if (csr_op_i == 2'b00) begin
      csr_op_i = csr_pkg::CSR_RW;
    end
    csr_addr_i = pick_addr(mode == T_CONFLICT && !chance(2));
    csr_operand_i = chance(3) ? '0 : take_bits(64);
    pc_i = take_bits(64);
    exception_cause_i = take_bits(64);
    exception_tval_i = take_bits(64);
    case (mode)
      T_EXC: begin
        exception_i = chance(2);
        mret_i = chance(3);
      end
      T_IRQ: begin
        exception_i = chance(5);
        mret_i = chance(3);
        timer_irq_i = !chance(3);
      end
      T_MRET: begin
        exception_i = chance(4);
        mret_i = chance(2);
      end
      T_CONFLICT: begin
        exception_i = chance(1);
        mret_i = 1'b0;
      end
      default: begin
        exception_i = 1'b0;
        mret_i = 1'b0;
      end
    endcase
    if (mode != T_IRQ && chance(4)) begin
      timer_irq_i = !timer_irq_i;
    end
  endtask

  // starts and ends at a falling edge
  task automatic close_test(input int id);
    idle_inputs();
    test_id = id;
    test_done = 1'b1;
    @(negedge clk);
    test_done = 1'b0;
    tests_run++;
  endtask

  task automatic run_phase(input int id, input int target);
    int start;
    int cycles;
    start = events_of(id);
    cycles = 0;
    while ((events_of(id) - start) < target && cycles < PHASE_LIMIT) begin
      drive_inputs(id);
      @(negedge clk);
      cycles++;
    end
    if ((events_of(id) - start) < target) begin
      $display("timeout in test %0d: saw %0d of %0d events in %0d cycles",
               id, events_of(id) - start, target, cycles);
      timeouts++;
    end
    close_test(id);
  endtask

  initial begin
    lfsr = SEED;
    reset_i = 1'b1;
    csr_valid_i = 1'b0;
    csr_op_i = csr_pkg::CSR_RW;
    csr_addr_i = '0;
    csr_operand_i = '0;
    exception_i = 1'b0;
    exception_cause_i = '0;
    exception_tval_i = '0;
    pc_i = '0;
    mret_i = 1'b0;
    timer_irq_i = 1'b0;
    test_done = 1'b0;
    test_id = T_RESET;
    tests_run = 0;
    timeouts = 0;
    for (int i = 0; i < RESET_CYCLES; i++) begin
      @(negedge clk);
    end
    reset_i = 1'b0;
    // every CSR once, then one unused address
    for (int i = 0; i < 8; i++) begin
      csr_addr_i = csr_at(i);
      @(negedge clk);
    end
    close_test(T_RESET);
    run_phase(T_CSR, 300);
    run_phase(T_EXC, 40);
    run_phase(T_IRQ, 20);
    run_phase(T_MRET, 40);
    run_phase(T_CONFLICT, 20);
    $display("summary: %0d tests, %0d checks, %0d check errors, %0d timeouts",
             tests_run, total_checks, total_errors, timeouts);
    if (total_errors == 0 && timeouts == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
hw/csr_pkg.sv
hw/trap_write_if.sv
hw/csr_op_unit.sv
hw/trap_unit.sv
hw/csr_regfile.sv
hw/csr_top.sv
tb/csr_checker.sv
tb/csr_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := csr_tb
FILELIST   := tb.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := Test completed successfully
VFLAGS     := --binary --timing --assert -j 0 --top-module $(TOP) --Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only -Wall --timing --top-module $(TOP)
SOURCES    := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
